// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f tb.f --top-module tb_br_exec -o tb_br_exec
	./obj_dir/tb_br_exec

clean:
	rm -rf obj_dir

// ==== tb.f ====
verilog/br_core_pkg.sv
verilog/br_issue_queue.sv
verilog/cdb_arbiter.sv
verilog/alu_unit.sv
verilog/mul_unit.sv
verilog/phys_regfile.sv
verilog/branch_unit.sv
verilog/br_exec_top.sv
test/tb_br_exec.sv

// ==== test/tb_br_exec.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_br_exec;
  import br_core_pkg::*;

  localparam int TMO = 200; // cycles per wait loop

  logic              clk, rst_n, flush;
  logic              br_disp_valid, br_disp_ready, br_is_jump, br_pred_taken;
  logic              br_rs1_ready, br_rs2_ready;
  logic [INST_W-1:0] br_inst_num, res_inst_num;
  logic [XLEN-1:0]   br_pc, br_imm, alu_a, alu_b, mul_a, mul_b, cdb_data, res_target;
  logic [2:0]        br_funct3;
  logic [PHYS_W-1:0] br_rd, br_rs1, br_rs2, alu_rd, mul_rd, cdb_tag;
  logic              alu_valid, alu_ready, mul_valid, mul_ready, cdb_valid;
  logic              res_valid, res_taken, res_mispredict;

  // shadow register values and broadcast bookkeeping
  logic [XLEN-1:0]     exp_val [NUM_PHYS];
  logic [NUM_PHYS-1:0] sent;
  logic [NUM_PHYS-1:0] seen;
  // expected resolves in dispatch order
  logic [INST_W-1:0]   e_num_q [64];
  logic [XLEN-1:0]     e_tgt_q [64];
  logic [PHYS_W-1:0]   e_rs1_q [64];
  logic [PHYS_W-1:0]   e_rs2_q [64];
  logic [63:0]         e_taken_q, e_mis_q;
  logic [5:0]          rd_ptr, wr_ptr;
  logic [INST_W-1:0]   inst_cnt;
  logic [PHYS_W-1:0]   tag_cnt;
  int                  seed = 32'hdc84629c;
  string               test_name;

  br_exec_top UUT (.*);

  always #5 clk = ~clk;

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) seen <= '0;
    else if (cdb_valid) seen[cdb_tag] <= 1'b1;
  end

  // a mispredict or flush drops every queued younger branch
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) rd_ptr <= '0;
    else if (flush || (res_valid && res_mispredict)) rd_ptr <= wr_ptr;
    else if (res_valid) rd_ptr <= rd_ptr + 1'b1;
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1, "stopping at first error");
  endtask

  function automatic logic branch_cond(input logic [2:0] f3, input logic [XLEN-1:0] a,
                                       input logic [XLEN-1:0] b);
    case (f3)
      F3_BEQ:  return a == b;
      F3_BNE:  return a != b;
      F3_BLT:  return $signed(a) < $signed(b);
      F3_BGE:  return !($signed(a) < $signed(b));
      F3_BLTU: return a < b;
      default: return !(a < b); // bgeu
    endcase
  endfunction

  a_cdb_known: assert property (@(posedge clk) disable iff (!rst_n)
    cdb_valid |-> sent[cdb_tag] && !seen[cdb_tag])
    else fail_run($sformatf("unexpected CDB broadcast of tag %0d", cdb_tag));
  a_cdb_data: assert property (@(posedge clk) disable iff (!rst_n)
    cdb_valid |-> cdb_data == exp_val[cdb_tag])
    else fail_run($sformatf("ERROR %s: cdb_data tag %0d expected %h actual %h",
                            test_name, cdb_tag, exp_val[cdb_tag], cdb_data));
  a_res_expected: assert property (@(posedge clk) disable iff (!rst_n)
    res_valid |-> rd_ptr != wr_ptr)
    else fail_run($sformatf("branch %0d resolved after it was squashed", res_inst_num));
  a_res_order: assert property (@(posedge clk) disable iff (!rst_n)
    res_valid |-> res_inst_num == e_num_q[rd_ptr])
    else fail_run($sformatf("ERROR %s: res_inst_num expected %0d actual %0d",
                            test_name, e_num_q[rd_ptr], res_inst_num));
  a_res_taken: assert property (@(posedge clk) disable iff (!rst_n)
    res_valid |-> res_taken == e_taken_q[rd_ptr])
    else fail_run($sformatf("ERROR %s: res_taken expected %0d actual %0d",
                            test_name, e_taken_q[rd_ptr], res_taken));
  a_res_target: assert property (@(posedge clk) disable iff (!rst_n)
    res_valid |-> res_target == e_tgt_q[rd_ptr])
    else fail_run($sformatf("ERROR %s: res_target expected %h actual %h",
                            test_name, e_tgt_q[rd_ptr], res_target));
  a_res_mispredict: assert property (@(posedge clk) disable iff (!rst_n)
    res_valid |-> res_mispredict == e_mis_q[rd_ptr])
    else fail_run($sformatf("ERROR %s: res_mispredict expected %0d actual %0d",
                            test_name, e_mis_q[rd_ptr], res_mispredict));
  a_res_deps: assert property (@(posedge clk) disable iff (!rst_n)
    res_valid |-> (e_rs1_q[rd_ptr] == '0 || seen[e_rs1_q[rd_ptr]])
               && (e_rs2_q[rd_ptr] == '0 || seen[e_rs2_q[rd_ptr]]))
    else fail_run($sformatf("branch %0d resolved before its source was broadcast",
                            res_inst_num));

  task automatic alloc_tag(output logic [PHYS_W-1:0] tag);
    tag     = tag_cnt;
    tag_cnt = tag_cnt + 1'b1;
  endtask

  // all send tasks start and end on a falling edge
  task automatic send_alu(input logic [PHYS_W-1:0] tag, input logic [XLEN-1:0] a,
                          input logic [XLEN-1:0] b);
    int t;
    t         = 0;
    alu_valid = 1'b1;
    alu_rd    = tag;
    alu_a     = a;
    alu_b     = b;
    while (!alu_ready) begin
      @(negedge clk);
      t++;
      if (t > TMO) fail_run("ALU dispatch never accepted");
    end
    exp_val[tag] = a + b;
    sent[tag]    = 1'b1;
    @(negedge clk);
    alu_valid = 1'b0;
  endtask

  task automatic send_mul(input logic [PHYS_W-1:0] tag, input logic [XLEN-1:0] a,
                          input logic [XLEN-1:0] b);
    int t;
    t         = 0;
    mul_valid = 1'b1;
    mul_rd    = tag;
    mul_a     = a;
    mul_b     = b;
    while (!mul_ready) begin
      @(negedge clk);
      t++;
      if (t > TMO) fail_run("multiplier dispatch never accepted");
    end
    exp_val[tag] = a * b;
    sent[tag]    = 1'b1;
    @(negedge clk);
    mul_valid = 1'b0;
  endtask

  // mode 0 predicts right, 1 predicts wrong, 2 predicts at random
  task automatic send_br(input logic [2:0] f3, input logic jmp, input int mode,
                         input logic [PHYS_W-1:0] rd, input logic [PHYS_W-1:0] rs1,
                         input logic [PHYS_W-1:0] rs2);
    logic [XLEN-1:0] r;
    logic [XLEN-1:0] pc;
    logic            tk;
    logic            pred;
    int              t;
    t  = 0;
    pc = $random(seed);
    pc = pc & 32'hffff_fffc;
    r  = $random(seed);
    tk = jmp ? 1'b1 : branch_cond(f3, exp_val[rs1], exp_val[rs2]);
    case (mode)
      0:       pred = tk;
      1:       pred = !tk;
      default: pred = r[31];
    endcase
    br_disp_valid = 1'b1;
    br_inst_num   = inst_cnt;
    br_pc         = pc;
    br_imm        = {{20{r[11]}}, r[11:1], 1'b0};
    br_funct3     = f3;
    br_is_jump    = jmp;
    br_pred_taken = pred;
    br_rd         = rd;
    br_rs1        = rs1;
    br_rs2        = rs2;
    br_rs1_ready  = (rs1 == '0) || seen[rs1];
    br_rs2_ready  = (rs2 == '0) || seen[rs2];
    while (!br_disp_ready) begin
      @(negedge clk);
      t++;
      if (t > TMO) fail_run("branch dispatch never accepted");
    end
    e_num_q[wr_ptr]   = inst_cnt;
    e_tgt_q[wr_ptr]   = pc + br_imm;
    e_rs1_q[wr_ptr]   = rs1;
    e_rs2_q[wr_ptr]   = rs2;
    e_taken_q[wr_ptr] = tk;
    e_mis_q[wr_ptr]   = tk != pred;
    wr_ptr            = wr_ptr + 1'b1;
    inst_cnt          = inst_cnt + 1'b1;
    if (jmp) begin
      exp_val[rd] = pc + 32'd4; // link value
      sent[rd]    = 1'b1;
    end
    @(negedge clk);
    br_disp_valid = 1'b0;
  endtask

  task automatic wait_resolved();
    int t;
    t = 0;
    while (rd_ptr != wr_ptr) begin
      @(negedge clk);
      t++;
      if (t > TMO) fail_run("timed out waiting for branch resolves");
    end
  endtask

  task automatic wait_cdb_idle();
    int t;
    t = 0;
    while ((sent & ~seen) != '0) begin
      @(negedge clk);
      t++;
      if (t > TMO) fail_run("timed out waiting for CDB broadcasts");
    end
  endtask

  // a few cycles with no resolve at all
  task automatic wait_quiet();
    int t;
    int quiet;
    t     = 0;
    quiet = 0;
    while (quiet < 4) begin
      @(negedge clk);
      quiet = res_valid ? 0 : quiet + 1;
      t++;
      if (t > TMO) fail_run("resolve output never went idle");
    end
  endtask

  initial begin
    logic [2:0]        conds [6];
    logic [PHYS_W-1:0] t1, t2;
    logic [XLEN-1:0]   v;
    conds = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
    clk = 1'b0;
    rst_n = 1'b0;
    flush = 1'b0;
    br_disp_valid = 1'b0;
    {br_inst_num, br_pc, br_imm, br_funct3, br_is_jump, br_pred_taken} = '0;
    {br_rd, br_rs1, br_rs2, br_rs1_ready, br_rs2_ready} = '0;
    {alu_valid, alu_rd, alu_a, alu_b, mul_valid, mul_rd, mul_a, mul_b} = '0;
    for (int i = 0; i < NUM_PHYS; i++) exp_val[i] = '0;
    sent = '0;
    wr_ptr = '0;
    inst_cnt = '0;
    tag_cnt = PHYS_W'(1); // tag 0 stays zero
    test_name = "reset";
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    test_name = "cdb_results";
    fork
      for (int i = 0; i < 4; i++) begin
        alloc_tag(t1);
        send_mul(t1, $random(seed), $random(seed));
      end
      for (int i = 0; i < 4; i++) begin
        alloc_tag(t2);
        send_alu(t2, $random(seed), $random(seed));
      end
    join
    wait_cdb_idle();

    test_name = "branch_conditions";
    for (int c = 0; c < 6; c++) begin
      for (int k = 0; k < 2; k++) begin
        alloc_tag(t1);
        alloc_tag(t2);
        send_mul(t1, $random(seed), $random(seed));
        if (k == 0) send_alu(t2, $random(seed), $random(seed));
        else send_alu(t2, exp_val[t1], '0); // equal operands
        send_br(conds[c], 1'b0, 2, '0, t1, t2);
        wait_resolved();
      end
    end

    test_name = "jump_link";
    alloc_tag(t1);
    alloc_tag(t2);
    send_br(F3_BEQ, 1'b1, 0, t1, '0, '0);
    send_alu(t2, exp_val[t1], '0);
    send_br(F3_BEQ, 1'b0, 0, '0, t1, t2);
    wait_resolved();
    wait_cdb_idle();

    test_name = "in_order";
    alloc_tag(t1);
    v = $random(seed);
    exp_val[t1] = v;
    send_br(F3_BLT, 1'b0, 0, '0, t1, '0);
    for (int c = 1; c < 4; c++) send_br(conds[c], 1'b0, 0, '0, PHYS_W'(1), PHYS_W'(2));
    send_alu(t1, v, '0);
    wait_resolved();

    test_name = "mispredict_squash";
    alloc_tag(t2);
    v = $random(seed);
    exp_val[t2] = v;
    send_br(F3_BGE, 1'b0, 1, '0, t2, '0);
    send_br(F3_BEQ, 1'b0, 0, '0, PHYS_W'(1), PHYS_W'(2));
    send_br(F3_BNE, 1'b0, 0, '0, PHYS_W'(2), PHYS_W'(1));
    send_alu(t2, v, '0);
    wait_resolved();
    wait_quiet();

    test_name = "full_flush";
    alloc_tag(t1);
    v = $random(seed);
    exp_val[t1] = v;
    for (int i = 0; i < RS_DEPTH; i++) send_br(conds[i % 6], 1'b0, 0, '0, t1, '0);
    assert (!br_disp_ready) else fail_run("br_disp_ready still high with the station full");
    flush = 1'b1;
    @(negedge clk);
    flush = 1'b0;
    assert (br_disp_ready) else fail_run("br_disp_ready low after flush");
    send_alu(t1, v, '0);
    wait_cdb_idle();
    wait_quiet();

    $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/alu_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_unit (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           in_valid,
  output logic                           in_ready,
  input  logic [br_core_pkg::PHYS_W-1:0] in_rd,
  input  logic [br_core_pkg::XLEN-1:0]   in_a,
  input  logic [br_core_pkg::XLEN-1:0]   in_b,
  output logic                           cdb_req,
  input  logic                           cdb_grant,
  output logic [br_core_pkg::PHYS_W-1:0] out_tag,
  output logic [br_core_pkg::XLEN-1:0]   out_data
);
  import br_core_pkg::*;

  // a granted result frees the slot for the next op
  assign in_ready = !cdb_req || cdb_grant;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) cdb_req <= 1'b0;
    else if (in_valid && in_ready) cdb_req <= 1'b1;
    else if (cdb_grant) cdb_req <= 1'b0;
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      out_tag  <= in_rd;
      out_data <= in_a + in_b;
    end
  end

  a_hold_until_grant: assert property (@(posedge clk) disable iff (!rst_n)
    (cdb_req && !cdb_grant) |=> cdb_req && $stable(out_tag) && $stable(out_data));

endmodule

`default_nettype wire

// ==== verilog/br_core_pkg.sv ====
`default_nettype none

package br_core_pkg;

  // datapath and tag widths
  localparam int XLEN     = 32;
  localparam int PHYS_W   = 6;
  localparam int NUM_PHYS = 64;

  // branch station geometry
  localparam int RS_DEPTH = 8;
  localparam int RS_PTR_W = 3;
  localparam int INST_W   = 16;

  // cdb producers
  localparam int NUM_PRODUCERS = 3;
  localparam int PROD_IDX_W    = $clog2(NUM_PRODUCERS);
  localparam int PROD_ALU      = 0;
  localparam int PROD_MUL      = 1;
  localparam int PROD_BR       = 2;

  localparam int MUL_STAGES = 3;

  // funct3 of the conditional branches
  localparam logic [2:0] F3_BEQ  = 3'd0;
  localparam logic [2:0] F3_BNE  = 3'd1;
  localparam logic [2:0] F3_BLT  = 3'd4;
  localparam logic [2:0] F3_BGE  = 3'd5;
  localparam logic [2:0] F3_BLTU = 3'd6;
  localparam logic [2:0] F3_BGEU = 3'd7;

endpackage

`default_nettype wire

// ==== verilog/br_exec_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module br_exec_top (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           flush,
  input  logic                           br_disp_valid,
  output logic                           br_disp_ready,
  input  logic [br_core_pkg::INST_W-1:0] br_inst_num,
  input  logic [br_core_pkg::XLEN-1:0]   br_pc,
  input  logic [br_core_pkg::XLEN-1:0]   br_imm,
  input  logic [2:0]                     br_funct3,
  input  logic                           br_is_jump,
  input  logic                           br_pred_taken,
  input  logic [br_core_pkg::PHYS_W-1:0] br_rd,
  input  logic [br_core_pkg::PHYS_W-1:0] br_rs1,
  input  logic [br_core_pkg::PHYS_W-1:0] br_rs2,
  input  logic                           br_rs1_ready,
  input  logic                           br_rs2_ready,
  input  logic                           alu_valid,
  output logic                           alu_ready,
  input  logic [br_core_pkg::PHYS_W-1:0] alu_rd,
  input  logic [br_core_pkg::XLEN-1:0]   alu_a,
  input  logic [br_core_pkg::XLEN-1:0]   alu_b,
  input  logic                           mul_valid,
  output logic                           mul_ready,
  input  logic [br_core_pkg::PHYS_W-1:0] mul_rd,
  input  logic [br_core_pkg::XLEN-1:0]   mul_a,
  input  logic [br_core_pkg::XLEN-1:0]   mul_b,
  output logic                           cdb_valid,
  output logic [br_core_pkg::PHYS_W-1:0] cdb_tag,
  output logic [br_core_pkg::XLEN-1:0]   cdb_data,
  output logic                           res_valid,
  output logic [br_core_pkg::INST_W-1:0] res_inst_num,
  output logic                           res_taken,
  output logic [br_core_pkg::XLEN-1:0]   res_target,
  output logic                           res_mispredict
);
  import br_core_pkg::*;

  logic                     q_flush;
  logic [NUM_PRODUCERS-1:0] req;
  logic [NUM_PRODUCERS-1:0] grant;
  logic [PHYS_W-1:0]        alu_tag, mul_tag, br_tag;
  logic [XLEN-1:0]          alu_data, mul_data, br_data;
  logic                     iss_valid, iss_ready, iss_is_jump, iss_pred_taken;
  logic [INST_W-1:0]        iss_inst_num;
  logic [XLEN-1:0]          iss_pc, iss_imm;
  logic [2:0]               iss_funct3;
  logic [PHYS_W-1:0]        iss_rd, iss_rs1, iss_rs2;
  logic [PHYS_W-1:0]        src1_tag, src2_tag;
  logic [XLEN-1:0]          src1_data, src2_data;

  // mispredict empties the station the edge after it resolves
  assign q_flush = flush || (res_valid && res_mispredict);

  // result bus driven by the granted producer
  assign cdb_valid = |grant;
  always_comb begin
    cdb_tag  = alu_tag;
    cdb_data = alu_data;
    if (grant[PROD_MUL]) begin
      cdb_tag  = mul_tag;
      cdb_data = mul_data;
    end else if (grant[PROD_BR]) begin
      cdb_tag  = br_tag;
      cdb_data = br_data;
    end
  end

  br_issue_queue u_queue (
    .clk, .rst_n, .flush(q_flush),
    .disp_valid(br_disp_valid), .disp_ready(br_disp_ready),
    .disp_inst_num(br_inst_num), .disp_pc(br_pc), .disp_imm(br_imm),
    .disp_funct3(br_funct3), .disp_is_jump(br_is_jump), .disp_pred_taken(br_pred_taken),
    .disp_rd(br_rd), .disp_rs1(br_rs1), .disp_rs2(br_rs2),
    .disp_rs1_ready(br_rs1_ready), .disp_rs2_ready(br_rs2_ready),
    .cdb_valid, .cdb_tag,
    .issue_ready(iss_ready), .issue_valid(iss_valid), .issue_inst_num(iss_inst_num),
    .issue_pc(iss_pc), .issue_imm(iss_imm), .issue_funct3(iss_funct3),
    .issue_is_jump(iss_is_jump), .issue_pred_taken(iss_pred_taken),
    .issue_rd(iss_rd), .issue_rs1(iss_rs1), .issue_rs2(iss_rs2)
  );

  cdb_arbiter u_arb (.clk, .rst_n, .req, .grant);

  alu_unit u_alu (
    .clk, .rst_n, .in_valid(alu_valid), .in_ready(alu_ready),
    .in_rd(alu_rd), .in_a(alu_a), .in_b(alu_b),
    .cdb_req(req[PROD_ALU]), .cdb_grant(grant[PROD_ALU]),
    .out_tag(alu_tag), .out_data(alu_data)
  );

  mul_unit u_mul (
    .clk, .rst_n, .in_valid(mul_valid), .in_ready(mul_ready),
    .in_rd(mul_rd), .in_a(mul_a), .in_b(mul_b),
    .cdb_req(req[PROD_MUL]), .cdb_grant(grant[PROD_MUL]),
    .out_tag(mul_tag), .out_data(mul_data)
  );

  phys_regfile u_prf (
    .clk, .rst_n, .wr_en(cdb_valid), .wr_tag(cdb_tag), .wr_data(cdb_data),
    .rd_tag1(src1_tag), .rd_tag2(src2_tag), .rd_data1(src1_data), .rd_data2(src2_data)
  );

  branch_unit u_bru (
    .clk, .rst_n, .issue_valid(iss_valid), .issue_ready(iss_ready),
    .issue_inst_num(iss_inst_num), .issue_pc(iss_pc), .issue_imm(iss_imm),
    .issue_funct3(iss_funct3), .issue_is_jump(iss_is_jump),
    .issue_pred_taken(iss_pred_taken), .issue_rd(iss_rd),
    .issue_rs1(iss_rs1), .issue_rs2(iss_rs2),
    .src1_tag, .src2_tag, .src1_data, .src2_data,
    .res_valid, .res_inst_num, .res_taken, .res_target, .res_mispredict,
    .cdb_req(req[PROD_BR]), .cdb_grant(grant[PROD_BR]),
    .out_tag(br_tag), .out_data(br_data)
  );

endmodule

`default_nettype wire

// ==== verilog/br_issue_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module br_issue_queue (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           flush,
  input  logic                           disp_valid,
  output logic                           disp_ready,
  input  logic [br_core_pkg::INST_W-1:0] disp_inst_num,
  input  logic [br_core_pkg::XLEN-1:0]   disp_pc,
  input  logic [br_core_pkg::XLEN-1:0]   disp_imm,
  input  logic [2:0]                     disp_funct3,
  input  logic                           disp_is_jump,
  input  logic                           disp_pred_taken,
  input  logic [br_core_pkg::PHYS_W-1:0] disp_rd,
  input  logic [br_core_pkg::PHYS_W-1:0] disp_rs1,
  input  logic [br_core_pkg::PHYS_W-1:0] disp_rs2,
  input  logic                           disp_rs1_ready,
  input  logic                           disp_rs2_ready,
  input  logic                           cdb_valid,
  input  logic [br_core_pkg::PHYS_W-1:0] cdb_tag,
  input  logic                           issue_ready,
  output logic                           issue_valid,
  output logic [br_core_pkg::INST_W-1:0] issue_inst_num,
  output logic [br_core_pkg::XLEN-1:0]   issue_pc,
  output logic [br_core_pkg::XLEN-1:0]   issue_imm,
  output logic [2:0]                     issue_funct3,
  output logic                           issue_is_jump,
  output logic                           issue_pred_taken,
  output logic [br_core_pkg::PHYS_W-1:0] issue_rd,
  output logic [br_core_pkg::PHYS_W-1:0] issue_rs1,
  output logic [br_core_pkg::PHYS_W-1:0] issue_rs2
);
  import br_core_pkg::*;

  logic [INST_W-1:0]   q_inst_num [RS_DEPTH];
  logic [XLEN-1:0]     q_pc       [RS_DEPTH];
  logic [XLEN-1:0]     q_imm      [RS_DEPTH];
  logic [2:0]          q_funct3   [RS_DEPTH];
  logic [PHYS_W-1:0]   q_rd       [RS_DEPTH];
  logic [PHYS_W-1:0]   q_rs1      [RS_DEPTH];
  logic [PHYS_W-1:0]   q_rs2      [RS_DEPTH];
  logic [RS_DEPTH-1:0] q_is_jump;
  logic [RS_DEPTH-1:0] q_pred_taken;
  logic [RS_DEPTH-1:0] q_rdy1;
  logic [RS_DEPTH-1:0] q_rdy2;
  logic [RS_PTR_W-1:0] head;
  logic [RS_PTR_W-1:0] tail;
  logic [RS_PTR_W:0]   count;
  logic                push;
  logic                pop;
  logic                head_ok;

  assign disp_ready = (count != (RS_PTR_W + 1)'(RS_DEPTH));
  assign push       = disp_valid && disp_ready;
  // only the head may go so branches leave in program order
  assign head_ok    = (count != '0) && q_rdy1[head] && q_rdy2[head];
  assign pop        = head_ok && issue_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      head        <= '0;
      tail        <= '0;
      count       <= '0;
      issue_valid <= 1'b0;
      q_rdy1      <= '0;
      q_rdy2      <= '0;
    end else if (flush) begin
      head        <= '0;
      tail        <= '0;
      count       <= '0;
      issue_valid <= 1'b0;
    end else begin
      if (cdb_valid) begin
        for (int i = 0; i < RS_DEPTH; i++) begin
          if (q_rs1[i] == cdb_tag) q_rdy1[i] <= 1'b1;
          if (q_rs2[i] == cdb_tag) q_rdy2[i] <= 1'b1;
        end
      end
      if (push) begin
        // same-cycle broadcast counts as ready
        q_rdy1[tail] <= disp_rs1_ready || (cdb_valid && cdb_tag == disp_rs1);
        q_rdy2[tail] <= disp_rs2_ready || (cdb_valid && cdb_tag == disp_rs2);
        tail         <= tail + 1'b1; // depth is a power of two
      end
      if (pop) head <= head + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      issue_valid <= pop;
    end
  end

  // entry payload and issue registers
  always_ff @(posedge clk) begin
    if (push) begin
      q_inst_num[tail]   <= disp_inst_num;
      q_pc[tail]         <= disp_pc;
      q_imm[tail]        <= disp_imm;
      q_funct3[tail]     <= disp_funct3;
      q_is_jump[tail]    <= disp_is_jump;
      q_pred_taken[tail] <= disp_pred_taken;
      q_rd[tail]         <= disp_rd;
      q_rs1[tail]        <= disp_rs1;
      q_rs2[tail]        <= disp_rs2;
    end
    if (pop) begin
      issue_inst_num   <= q_inst_num[head];
      issue_pc         <= q_pc[head];
      issue_imm        <= q_imm[head];
      issue_funct3     <= q_funct3[head];
      issue_is_jump    <= q_is_jump[head];
      issue_pred_taken <= q_pred_taken[head];
      issue_rd         <= q_rd[head];
      issue_rs1        <= q_rs1[head];
      issue_rs2        <= q_rs2[head];
    end
  end

  // occupancy never passes the depth and the pointers agree with it
  a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
    count <= (RS_PTR_W + 1)'(RS_DEPTH) && tail == head + count[RS_PTR_W-1:0]);

  // an emptied station has nothing to issue for two cycles
  a_flush_kills_issue: assert property (@(posedge clk) disable iff (!rst_n)
    flush |=> !issue_valid [*2]);

endmodule

`default_nettype wire

// ==== verilog/branch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module branch_unit (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           issue_valid,
  output logic                           issue_ready,
  input  logic [br_core_pkg::INST_W-1:0] issue_inst_num,
  input  logic [br_core_pkg::XLEN-1:0]   issue_pc,
  input  logic [br_core_pkg::XLEN-1:0]   issue_imm,
  input  logic [2:0]                     issue_funct3,
  input  logic                           issue_is_jump,
  input  logic                           issue_pred_taken,
  input  logic [br_core_pkg::PHYS_W-1:0] issue_rd,
  input  logic [br_core_pkg::PHYS_W-1:0] issue_rs1,
  input  logic [br_core_pkg::PHYS_W-1:0] issue_rs2,
  output logic [br_core_pkg::PHYS_W-1:0] src1_tag,
  output logic [br_core_pkg::PHYS_W-1:0] src2_tag,
  input  logic [br_core_pkg::XLEN-1:0]   src1_data,
  input  logic [br_core_pkg::XLEN-1:0]   src2_data,
  output logic                           res_valid,
  output logic [br_core_pkg::INST_W-1:0] res_inst_num,
  output logic                           res_taken,
  output logic [br_core_pkg::XLEN-1:0]   res_target,
  output logic                           res_mispredict,
  output logic                           cdb_req,
  input  logic                           cdb_grant,
  output logic [br_core_pkg::PHYS_W-1:0] out_tag,
  output logic [br_core_pkg::XLEN-1:0]   out_data
);
  import br_core_pkg::*;

  logic cond;
  logic taken;
  logic accept;

  assign src1_tag = issue_rs1;
  assign src2_tag = issue_rs2;

  always_comb begin
    case (issue_funct3)
      F3_BEQ:  cond = (src1_data == src2_data);
      F3_BNE:  cond = (src1_data != src2_data);
      F3_BLT:  cond = ($signed(src1_data) < $signed(src2_data));
      F3_BGE:  cond = ($signed(src1_data) >= $signed(src2_data));
      F3_BLTU: cond = (src1_data < src2_data);
      F3_BGEU: cond = (src1_data >= src2_data);
      default: cond = 1'b0;
    endcase
  end

  assign taken = issue_is_jump || cond; // jumps always go

  // an op issued behind a mispredict is dropped here
  assign accept = issue_valid && !(res_valid && res_mispredict);

  // no new op while a link write is pending or about to be
  assign issue_ready = !(issue_valid && issue_is_jump) && (!cdb_req || cdb_grant);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      res_valid      <= 1'b0;
      res_mispredict <= 1'b0;
      cdb_req        <= 1'b0;
    end else begin
      res_valid      <= accept;
      res_mispredict <= accept && (taken != issue_pred_taken);
      if (accept && issue_is_jump) cdb_req <= 1'b1;
      else if (cdb_grant) cdb_req <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      res_inst_num <= issue_inst_num;
      res_taken    <= taken;
      res_target   <= issue_pc + issue_imm;
    end
    if (accept && issue_is_jump) begin
      out_tag  <= issue_rd;
      out_data <= issue_pc + XLEN'(4); // link value
    end
  end

  // the station holds back while a link write waits for the bus
  a_no_issue_during_link: assert property (@(posedge clk) disable iff (!rst_n)
    (cdb_req && !cdb_grant) |=> !issue_valid);

endmodule

`default_nettype wire

// ==== verilog/cdb_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module cdb_arbiter (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic [br_core_pkg::NUM_PRODUCERS-1:0] req,
  output logic [br_core_pkg::NUM_PRODUCERS-1:0] grant
);
  import br_core_pkg::*;

  logic [PROD_IDX_W-1:0] last;
  logic [PROD_IDX_W-1:0] gnt_idx;
  int                    idx;

  // search starts just after the last winner
  always_comb begin
    grant   = '0;
    gnt_idx = last;
    for (int k = 1; k <= NUM_PRODUCERS; k++) begin
      idx = int'(last) + k;
      if (idx >= NUM_PRODUCERS) idx = idx - NUM_PRODUCERS;
      if (grant == '0 && req[idx]) begin
        grant[idx] = 1'b1;
        gnt_idx    = PROD_IDX_W'(idx);
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) last <= PROD_IDX_W'(NUM_PRODUCERS - 1); // alu wins first
    else if (|grant) last <= gnt_idx;
  end

  a_grant_legal: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(grant) && ((grant & ~req) == '0));

endmodule

`default_nettype wire

// ==== verilog/mul_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module mul_unit (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           in_valid,
  output logic                           in_ready,
  input  logic [br_core_pkg::PHYS_W-1:0] in_rd,
  input  logic [br_core_pkg::XLEN-1:0]   in_a,
  input  logic [br_core_pkg::XLEN-1:0]   in_b,
  output logic                           cdb_req,
  input  logic                           cdb_grant,
  output logic [br_core_pkg::PHYS_W-1:0] out_tag,
  output logic [br_core_pkg::XLEN-1:0]   out_data
);
  import br_core_pkg::*;

  logic [MUL_STAGES-1:0] st_valid;
  logic [PHYS_W-1:0]     st_tag  [MUL_STAGES];
  logic [XLEN-1:0]       st_prod [MUL_STAGES];
  logic                  stall;

  // last stage waiting on the bus freezes the whole pipe
  assign stall    = st_valid[MUL_STAGES-1] && !cdb_grant;
  assign in_ready = !stall;
  assign cdb_req  = st_valid[MUL_STAGES-1];
  assign out_tag  = st_tag[MUL_STAGES-1];
  assign out_data = st_prod[MUL_STAGES-1];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) st_valid <= '0;
    else if (!stall) st_valid <= {st_valid[MUL_STAGES-2:0], in_valid};
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      st_tag[0]  <= in_rd;
      st_prod[0] <= in_a * in_b; // low XLEN bits only
      for (int s = 1; s < MUL_STAGES; s++) begin
        st_tag[s]  <= st_tag[s-1];
        st_prod[s] <= st_prod[s-1];
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/phys_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module phys_regfile (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           wr_en,
  input  logic [br_core_pkg::PHYS_W-1:0] wr_tag,
  input  logic [br_core_pkg::XLEN-1:0]   wr_data,
  input  logic [br_core_pkg::PHYS_W-1:0] rd_tag1,
  input  logic [br_core_pkg::PHYS_W-1:0] rd_tag2,
  output logic [br_core_pkg::XLEN-1:0]   rd_data1,
  output logic [br_core_pkg::XLEN-1:0]   rd_data2
);
  import br_core_pkg::*;

  logic [XLEN-1:0] regs [NUM_PHYS];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_PHYS; i++) regs[i] <= '0;
    end else if (wr_en) begin
      regs[wr_tag] <= wr_data; // cdb write
    end
  end

  assign rd_data1 = regs[rd_tag1];
  assign rd_data2 = regs[rd_tag2];

endmodule

`default_nettype wire
